// File: bench/dsp_core_tb.sv
`timescale 1ns/1ps

module dsp_core_tb;

   localparam int bus_timeout = 200;
   localparam int frame_p     = 40;

   logic                dsp_clk;
   logic                dsp_reset;
   dsp_pkg::bus_req_t   req;
   logic                req_valid;
   logic                req_ready;
   logic [31:0]         rsp_data;
   logic                rsp_valid;
   logic                rsp_ready;
   dsp_pkg::dac_frame_t dac_in;
   dsp_pkg::dac_frame_t dac_out;
   logic [7:0]          dac_val;
   logic [1:0]          trigger_out;

   // register model and checker state
   logic [7:0]          mask_model;
   logic [15:0]         dc_model [dsp_pkg::n_dac];
   logic [31:0]         period_model [dsp_pkg::n_trig];
   dsp_pkg::dac_frame_t exp_frame;
   logic [31:0]         exp_rsp;
   logic [31:0]         held_rsp;
   logic [31:0]         last_rd;
   logic [31:0]         gap;
   logic                rsp_check;
   logic                have_prev;
   logic                dac_chk;
   logic                bp_on;
   int                  pending;
   logic [31:0]         main_lfsr;
   logic [31:0]         data_lfsr;

   tb_clock clk_gen (.dsp_clk(dsp_clk), .dsp_reset(dsp_reset));

   dsp_core uut (
      .dsp_clk     (dsp_clk),
      .dsp_reset   (dsp_reset),
      .req         (req),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .rsp_data    (rsp_data),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .dac_in      (dac_in),
      .dac_out     (dac_out),
      .dac_val     (dac_val),
      .trigger_out (trigger_out)
   );

   // right-shifting form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++) begin
         v[b] = main_lfsr[0];
         main_lfsr = lfsr_next(main_lfsr);
      end
   endtask

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("error at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("timed out at %0t ns waiting for %s", $time, what);
      abort_run();
   endtask

   // read value the register bank should return per the model
   function automatic logic [31:0] expected_read(input logic [19:0] a);
      if (a >= dsp_pkg::addr_dac_dc0 && a <= dsp_pkg::addr_dac_dc7) begin
         return {16'h0, dc_model[a[2:0]]};
      end
      case (a)
         dsp_pkg::addr_valid:         return {24'h0, mask_model};
         dsp_pkg::addr_period_frame:  return period_model[0];
         dsp_pkg::addr_period_stream: return period_model[1];
         default:                     return dsp_pkg::bad_read;
      endcase
   endfunction

   task automatic bus_access(input logic [19:0] a, input logic [31:0] d, input logic w,
                             input logic check, input logic [31:0] expected);
      int n;
      @(posedge dsp_clk);
      req       <= '{addr: a, wdata: d, write: w};
      req_valid <= 1'b1;
      exp_rsp   <= expected;
      rsp_check <= check;
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
      end while (!req_ready && n < bus_timeout);
      if (!req_ready) begin
         report_timeout("req_ready");
      end
      @(posedge dsp_clk);
      req_valid <= 1'b0;
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
      end while (!(rsp_valid && rsp_ready) && n < bus_timeout);
      if (!(rsp_valid && rsp_ready)) begin
         report_timeout("bus response");
      end
      last_rd = rsp_data;
   endtask

   task automatic write_reg(input logic [19:0] a, input logic [31:0] d);
      bus_access(a, d, 1'b1, 1'b1, 32'h0);
   endtask

   // arm, poll done, then read back all words
   task automatic run_capture(input dsp_pkg::mon_src_e src);
      int polls;
      write_reg(dsp_pkg::addr_mon_sel, {27'h0, src});
      write_reg(dsp_pkg::addr_start, 32'h1);
      polls = 0;
      do begin
         bus_access(dsp_pkg::addr_mon_done, 32'h0, 1'b0, 1'b0, 32'h0);
         polls++;
      end while (last_rd != 32'h1 && polls < 100);
      if (last_rd != 32'h1) begin
         report_timeout("capture done");
      end
      for (int i = 0; i < dsp_pkg::mon_depth; i++) begin
         if (src == dsp_pkg::mon_const) begin
            bus_access({dsp_pkg::mon_page, 12'(i)}, 32'h0, 1'b0, 1'b1, 32'hdead);
         end else begin
            // word 0 holds the count from before the trigger
            bus_access({dsp_pkg::mon_page, 12'(i)}, 32'h0, 1'b0, i != 0,
                       32'((i + frame_p - 1) % frame_p));
         end
      end
   endtask

   // stimulus source with one LFSR bit per data bit
   always @(posedge dsp_clk) begin
      logic [511:0] frame;
      for (int b = 0; b < 512; b++) begin
         frame[b] = data_lfsr[0];
         data_lfsr = lfsr_next(data_lfsr);
      end
      dac_in <= frame;
      if (bp_on) begin
         rsp_ready <= data_lfsr[0];
         data_lfsr = lfsr_next(data_lfsr);
      end else begin
         rsp_ready <= 1'b1;
      end
   end

   // register model follows accepted writes
   always @(posedge dsp_clk) begin
      held_rsp <= rsp_data;
      for (int i = 0; i < dsp_pkg::n_dac * dsp_pkg::n_slice; i++) begin
         exp_frame.smp[i] <= dac_in.smp[i] + dc_model[i / dsp_pkg::n_slice];
      end
      if (dsp_reset) begin
         mask_model <= dsp_pkg::mask_reset;
         for (int k = 0; k < dsp_pkg::n_dac; k++) begin
            dc_model[k] <= '0;
         end
         period_model[0] <= dsp_pkg::default_period;
         period_model[1] <= dsp_pkg::default_period;
         pending   <= 0;
         gap       <= '0;
         have_prev <= 1'b0;
         dac_chk   <= 1'b0;
      end else begin
         dac_chk <= 1'b1;
         gap     <= trigger_out[1] ? 32'd1 : gap + 1;
         if (req_valid && req_ready) begin
            pending <= pending + 1;
            if (req.write) begin
               case (req.addr)
                  dsp_pkg::addr_valid:         mask_model <= req.wdata[7:0];
                  dsp_pkg::addr_period_frame:  period_model[0] <= req.wdata;
                  dsp_pkg::addr_period_stream: period_model[1] <= req.wdata;
                  default: begin
                     if (req.addr >= dsp_pkg::addr_dac_dc0 &&
                         req.addr <= dsp_pkg::addr_dac_dc7) begin
                        dc_model[req.addr[2:0]] <= req.wdata[15:0];
                     end
                  end
               endcase
            end
         end else if (rsp_valid && rsp_ready) begin
            pending <= pending - 1;
         end
         // spacing is measured only between pulses of one period setting
         if (req_valid && req_ready && req.write && req.addr == dsp_pkg::addr_period_stream) begin
            have_prev <= 1'b0;
         end else if (trigger_out[1]) begin
            have_prev <= 1'b1;
         end
      end
   end

   // first cycle out of reset
   assert property (@(posedge dsp_clk) $fell(dsp_reset) |-> dac_val == 8'hff)
      else report_mismatch("dac_val", 32'hff, $sampled(dac_val));
   assert property (@(posedge dsp_clk) $fell(dsp_reset) |-> req_ready)
      else report_mismatch("req_ready", 32'h1, $sampled(req_ready));
   assert property (@(posedge dsp_clk) $fell(dsp_reset) |-> !rsp_valid)
      else report_mismatch("rsp_valid", 32'h0, $sampled(rsp_valid));

   assert property (@(posedge dsp_clk) disable iff (dsp_reset) dac_val == mask_model)
      else report_mismatch("dac_val", $sampled(mask_model), $sampled(dac_val));
   assert property (@(posedge dsp_clk) disable iff (dsp_reset)
      rsp_valid && rsp_ready && rsp_check |-> rsp_data == exp_rsp)
      else report_mismatch("rsp_data", $sampled(exp_rsp), $sampled(rsp_data));

   // bus handshake under back-pressure
   assert property (@(posedge dsp_clk) disable iff (dsp_reset)
      rsp_valid && !rsp_ready |=> rsp_valid && rsp_data == held_rsp)
      else report_mismatch("rsp_data", $sampled(held_rsp), $sampled(rsp_data));
   assert property (@(posedge dsp_clk) disable iff (dsp_reset) rsp_valid |-> !req_ready)
      else report_mismatch("req_ready", 32'h0, $sampled(req_ready));
   assert property (@(posedge dsp_clk) disable iff (dsp_reset) rsp_valid == (pending == 1))
      else report_mismatch("outstanding requests", 32'($sampled(rsp_valid)), $sampled(pending));

   // stream trigger
   assert property (@(posedge dsp_clk) disable iff (dsp_reset) trigger_out[0] == trigger_out[1])
      else report_mismatch("trigger_out[0]", $sampled(trigger_out[1]), $sampled(trigger_out[0]));
   assert property (@(posedge dsp_clk) disable iff (dsp_reset) trigger_out[1] |=> !trigger_out[1])
      else report_mismatch("trigger_out[1]", 32'h0, $sampled(trigger_out[1]));
   assert property (@(posedge dsp_clk) disable iff (dsp_reset)
      have_prev && trigger_out[1] |-> gap == period_model[1])
      else report_mismatch("trigger_out spacing", $sampled(period_model[1]), $sampled(gap));

   for (genvar i = 0; i < dsp_pkg::n_dac * dsp_pkg::n_slice; i++) begin : g_dac_chk
      assert property (@(posedge dsp_clk) disable iff (dsp_reset)
         dac_chk |-> dac_out.smp[i] == exp_frame.smp[i])
         else report_mismatch($sformatf("dac_out.smp[%0d]", i),
                              {16'h0, $sampled(exp_frame.smp[i])},
                              {16'h0, $sampled(dac_out.smp[i])});
   end

   initial begin
      logic [31:0] v;
      int cyc;
      int seen;
      req       = '0;
      req_valid = 1'b0;
      rsp_ready = 1'b1;
      dac_in    = '0;
      bp_on     = 1'b0;
      rsp_check = 1'b0;
      exp_rsp   = '0;
      main_lfsr = 32'd58;
      data_lfsr = 32'd58;
      cyc = 0;
      do begin
         @(negedge dsp_clk);
         cyc++;
      end while (dsp_reset && cyc < 50);
      if (dsp_reset) begin
         report_timeout("reset release");
      end

      bus_access(dsp_pkg::addr_valid, 32'h0, 1'b0, 1'b1, 32'hff);
      bus_access(20'h50001, 32'h0, 1'b0, 1'b1, dsp_pkg::bad_read);
      write_reg(20'h50003, 32'h1234);

      // register write and read back with dc values left random for the DAC check
      for (int k = 0; k < dsp_pkg::n_dac; k++) begin
         rand_bits(32, v);
         write_reg(20'(dsp_pkg::addr_dac_dc0 + k), v);
         bus_access(20'(dsp_pkg::addr_dac_dc0 + k), 32'h0, 1'b0, 1'b1,
                    expected_read(20'(dsp_pkg::addr_dac_dc0 + k)));
         repeat (3) @(posedge dsp_clk);
      end
      for (int k = 0; k < 3; k++) begin
         rand_bits(32, v);
         write_reg(dsp_pkg::addr_valid, v);
         bus_access(dsp_pkg::addr_valid, 32'h0, 1'b0, 1'b1, expected_read(dsp_pkg::addr_valid));
         rand_bits(32, v);
         write_reg(20'(dsp_pkg::addr_period_frame + k % 2), v);
         bus_access(20'(dsp_pkg::addr_period_frame + k % 2), 32'h0, 1'b0, 1'b1,
                    expected_read(20'(dsp_pkg::addr_period_frame + k % 2)));
      end

      // stream period between 5 and 20
      for (int t = 0; t < 4; t++) begin
         rand_bits(4, v);
         write_reg(dsp_pkg::addr_period_stream, 32'd5 + v);
         seen = 0;
         cyc  = 0;
         while (seen < 5 && cyc < 300) begin
            @(negedge dsp_clk);
            cyc++;
            if (trigger_out[1]) begin
               seen++;
            end
         end
         if (seen < 5) begin
            report_timeout("stream trigger pulses");
         end
      end

      write_reg(dsp_pkg::addr_period_frame, frame_p);
      run_capture(dsp_pkg::mon_count);
      run_capture(dsp_pkg::mon_const);

      // random rsp_ready spans
      @(posedge dsp_clk);
      bp_on <= 1'b1;
      for (int k = 0; k < 8; k++) begin
         rand_bits(32, v);
         write_reg(20'(dsp_pkg::addr_dac_dc0 + k), v);
         bus_access(20'(dsp_pkg::addr_dac_dc0 + k), 32'h0, 1'b0, 1'b1,
                    expected_read(20'(dsp_pkg::addr_dac_dc0 + k)));
         bus_access(dsp_pkg::addr_valid, 32'h0, 1'b0, 1'b1, expected_read(dsp_pkg::addr_valid));
      end
      @(posedge dsp_clk);
      bp_on <= 1'b0;
      repeat (4) @(posedge dsp_clk);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic dsp_clk,
   output logic dsp_reset
);

   initial begin
      dsp_clk   = 1'b0;
      dsp_reset = 1'b1;
      repeat (8) @(posedge dsp_clk);
      dsp_reset <= 1'b0;
   end

   // 4 ns period
   always #2 dsp_clk = ~dsp_clk;

endmodule

// File: src/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs (
   input  logic                 dsp_clk,
   input  logic                 dsp_reset,
   input  dsp_pkg::bus_req_t    req,
   input  logic                 req_valid,
   output logic                 req_ready,
   output logic [31:0]          rsp_data,
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   input  dsp_pkg::sample_t     mon_rdata,
   input  logic                 mon_done,
   output dsp_pkg::dac_dc_t     dac_dc,
   output dsp_pkg::period_set_t period_set,
   output dsp_pkg::mon_cfg_t    mon_cfg,
   output logic [7:0]           valid_mask,
   output logic                 arm,
   output logic [1:0]           period_load
);

   dsp_pkg::reg_addr_e req_addr;
   logic               accept;
   logic               wr_stb;
   logic [31:0]        rd_word;

   // only one request in flight until its response drains
   assign req_ready = !rsp_valid;
   assign accept    = req_valid && req_ready;
   assign wr_stb    = accept && req.write;
   assign req_addr  = dsp_pkg::reg_addr_e'(req.addr);

   // strobes land on the accept edge together with the register update
   assign arm            = wr_stb && (req_addr == dsp_pkg::addr_start);
   assign period_load[0] = wr_stb && (req_addr == dsp_pkg::addr_period_frame);
   assign period_load[1] = wr_stb && (req_addr == dsp_pkg::addr_period_stream);

   always_ff @(posedge dsp_clk) begin
      if (dsp_reset) begin
         valid_mask <= dsp_pkg::mask_reset;
         mon_cfg    <= '0;
         dac_dc     <= '0;
         for (int j = 0; j < dsp_pkg::n_trig; j++) begin
            period_set[j] <= dsp_pkg::default_period;
         end
      end else if (wr_stb) begin
         case (req_addr)
            dsp_pkg::addr_valid:         valid_mask <= req.wdata[7:0];
            dsp_pkg::addr_mon_slice:     mon_cfg.slice <= req.wdata[1:0];
            dsp_pkg::addr_mon_sel:       mon_cfg.source <= dsp_pkg::mon_src_e'(req.wdata[4:0]);
            dsp_pkg::addr_period_frame:  period_set[0] <= req.wdata;
            dsp_pkg::addr_period_stream: period_set[1] <= req.wdata;
            dsp_pkg::addr_dac_dc0, dsp_pkg::addr_dac_dc1,
            dsp_pkg::addr_dac_dc2, dsp_pkg::addr_dac_dc3,
            dsp_pkg::addr_dac_dc4, dsp_pkg::addr_dac_dc5,
            dsp_pkg::addr_dac_dc6, dsp_pkg::addr_dac_dc7: begin
               dac_dc[req.addr[2:0]] <= req.wdata[15:0];
            end
            // start, done and unmapped writes change no storage
            default: ;
         endcase
      end
   end

   // read mux on the accepted address
   always_comb begin
      rd_word = dsp_pkg::bad_read;
      if (req.addr[19:12] == dsp_pkg::mon_page) begin
         rd_word = {16'h0, mon_rdata};
      end else begin
         case (req_addr)
            dsp_pkg::addr_valid:         rd_word = {24'h0, valid_mask};
            dsp_pkg::addr_start:         rd_word = '0;
            dsp_pkg::addr_mon_slice:     rd_word = {30'h0, mon_cfg.slice};
            dsp_pkg::addr_mon_sel:       rd_word = {27'h0, mon_cfg.source};
            dsp_pkg::addr_mon_done:      rd_word = {31'h0, mon_done};
            dsp_pkg::addr_period_frame:  rd_word = period_set[0];
            dsp_pkg::addr_period_stream: rd_word = period_set[1];
            dsp_pkg::addr_dac_dc0, dsp_pkg::addr_dac_dc1,
            dsp_pkg::addr_dac_dc2, dsp_pkg::addr_dac_dc3,
            dsp_pkg::addr_dac_dc4, dsp_pkg::addr_dac_dc5,
            dsp_pkg::addr_dac_dc6, dsp_pkg::addr_dac_dc7: begin
               rd_word = {16'h0, dac_dc[req.addr[2:0]]};
            end
            default: rd_word = dsp_pkg::bad_read;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (dsp_reset) begin
         rsp_valid <= 1'b0;
      end else if (accept) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   // held until consumed since no accept happens while rsp_valid is high
   always_ff @(posedge dsp_clk) begin
      if (accept) begin
         rsp_data <= req.write ? 32'h0 : rd_word;
      end
   end

endmodule

// File: src/dac_offset.sv
`timescale 1ns/1ps

module dac_offset (
   input  logic                dsp_clk,
   input  logic                dsp_reset,
   input  dsp_pkg::dac_frame_t dac_in,
   input  dsp_pkg::dac_dc_t    dac_dc,
   input  logic [7:0]          valid_mask,
   output dsp_pkg::dac_frame_t dac_out,
   output logic [7:0]          dac_val
);

   // one adder per slice with all slices of a channel sharing its offset
   always_ff @(posedge dsp_clk) begin
      if (dsp_reset) begin
         // DAC sees mid-scale while the core is held in reset
         dac_out <= '0;
      end else begin
         for (int k = 0; k < dsp_pkg::n_dac; k++) begin
            for (int s = 0; s < dsp_pkg::n_slice; s++) begin
               // 16-bit wrap without saturation
               dac_out.smp[k*dsp_pkg::n_slice+s] <=
                  dac_in.smp[k*dsp_pkg::n_slice+s] + dac_dc[k];
            end
         end
      end
   end

   // valid bits follow the mask register directly
   assign dac_val = valid_mask;

endmodule

// File: src/dsp_core.sv
`timescale 1ns/1ps

module dsp_core (
   input  logic                dsp_clk,
   input  logic                dsp_reset,
   input  dsp_pkg::bus_req_t   req,
   input  logic                req_valid,
   output logic                req_ready,
   output logic [31:0]         rsp_data,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   input  dsp_pkg::dac_frame_t dac_in,
   output dsp_pkg::dac_frame_t dac_out,
   output logic [7:0]          dac_val,
   output logic [1:0]          trigger_out
);

   dsp_pkg::dac_dc_t     dac_dc;
   dsp_pkg::period_set_t period_set;
   dsp_pkg::mon_cfg_t    mon_cfg;
   logic [7:0]           valid_mask;
   logic                 arm;
   logic [1:0]           period_load;
   logic [1:0]           trig;
   dsp_pkg::sample_t     mon_sample;
   dsp_pkg::sample_t     mon_rdata;
   logic                 mon_done;

   ctrl_regs u_regs (
      .dsp_clk     (dsp_clk),
      .dsp_reset   (dsp_reset),
      .req         (req),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .rsp_data    (rsp_data),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .mon_rdata   (mon_rdata),
      .mon_done    (mon_done),
      .dac_dc      (dac_dc),
      .period_set  (period_set),
      .mon_cfg     (mon_cfg),
      .valid_mask  (valid_mask),
      .arm         (arm),
      .period_load (period_load)
   );

   trigger_bank u_trig (
      .dsp_clk     (dsp_clk),
      .dsp_reset   (dsp_reset),
      .period_set  (period_set),
      .period_load (period_load),
      .trig        (trig)
   );

   // stream trigger drives both pins
   assign trigger_out = {2{trig[1]}};

   dac_offset u_dac (
      .dsp_clk    (dsp_clk),
      .dsp_reset  (dsp_reset),
      .dac_in     (dac_in),
      .dac_dc     (dac_dc),
      .valid_mask (valid_mask),
      .dac_out    (dac_out),
      .dac_val    (dac_val)
   );

   monitor_select u_mon_sel (
      .dsp_clk    (dsp_clk),
      .dsp_reset  (dsp_reset),
      .dac_out    (dac_out),
      .mon_cfg    (mon_cfg),
      .frame_trig (trig[0]),
      .mon_sample (mon_sample)
   );

   // memory read address comes straight off the bus request
   monitor_capture u_mon_cap (
      .dsp_clk    (dsp_clk),
      .dsp_reset  (dsp_reset),
      .arm        (arm),
      .frame_trig (trig[0]),
      .mon_sample (mon_sample),
      .rd_addr    (req.addr[5:0]),
      .mon_rdata  (mon_rdata),
      .mon_done   (mon_done)
   );

endmodule

// File: src/dsp_pkg.sv
package dsp_pkg;

   // board-fixed sizes
   localparam int n_dac    = 8;
   localparam int n_slice  = 4;
   localparam int sample_w = 16;
   localparam int addr_w   = 20;
   localparam int data_w   = 32;
   localparam int n_trig   = 2;
   localparam int period_w = 32;
   localparam int mon_aw   = 6;
   localparam int mon_depth = 64;

   // reset and fixed values
   // 400 Hz trigger rate at a 100 MHz dsp_clk
   localparam logic [period_w-1:0] default_period = 32'd250000;
   localparam logic [7:0]          mask_reset     = 8'hff;
   localparam logic [sample_w-1:0] mon_const_val  = 16'hdead;
   localparam logic [data_w-1:0]   bad_read       = 32'hdeadbeaf;
   // address bits 19:12 of the monitor memory window
   localparam logic [7:0]          mon_page       = 8'h72;

   typedef enum logic [addr_w-1:0] {
      addr_valid         = 20'h50000,
      addr_start         = 20'h50002,
      addr_mon_slice     = 20'h50008,
      addr_mon_sel       = 20'h50009,
      addr_mon_done      = 20'h50010,
      addr_dac_dc0       = 20'h50020,
      addr_dac_dc1       = 20'h50021,
      addr_dac_dc2       = 20'h50022,
      addr_dac_dc3       = 20'h50023,
      addr_dac_dc4       = 20'h50024,
      addr_dac_dc5       = 20'h50025,
      addr_dac_dc6       = 20'h50026,
      addr_dac_dc7       = 20'h50027,
      addr_period_frame  = 20'h50030,
      addr_period_stream = 20'h50031
   } reg_addr_e;

   // unlisted codes fall back to channel 0
   typedef enum logic [4:0] {
      mon_dac0  = 5'h00,
      mon_dac1  = 5'h01,
      mon_dac2  = 5'h02,
      mon_dac3  = 5'h03,
      mon_dac4  = 5'h04,
      mon_dac5  = 5'h05,
      mon_dac6  = 5'h06,
      mon_dac7  = 5'h07,
      mon_const = 5'h10,
      mon_count = 5'h11
   } mon_src_e;

   typedef logic signed [sample_w-1:0] sample_t;

   // channel k slice s at smp[k*n_slice+s]
   typedef struct packed {
      sample_t [n_dac*n_slice-1:0] smp;
   } dac_frame_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic              write;
   } bus_req_t;

   typedef sample_t [n_dac-1:0] dac_dc_t;

   // index 0 frame, index 1 stream
   typedef logic [n_trig-1:0][period_w-1:0] period_set_t;

   typedef struct packed {
      logic [1:0] slice;
      mon_src_e   source;
   } mon_cfg_t;

endpackage

// File: src/monitor_capture.sv
`timescale 1ns/1ps

module monitor_capture (
   input  logic             dsp_clk,
   input  logic             dsp_reset,
   input  logic             arm,
   input  logic             frame_trig,
   input  dsp_pkg::sample_t mon_sample,
   input  logic [5:0]       rd_addr,
   output dsp_pkg::sample_t mon_rdata,
   output logic             mon_done
);

   typedef enum logic [1:0] {
      cap_idle,
      cap_armed,
      cap_run
   } cap_state_e;

   cap_state_e                 state;
   logic [dsp_pkg::mon_aw-1:0] waddr;
   logic                       last_word;
   dsp_pkg::sample_t           mem [dsp_pkg::mon_depth];

   assign last_word = (waddr == dsp_pkg::mon_aw'(dsp_pkg::mon_depth - 1));

   always_ff @(posedge dsp_clk) begin
      if (dsp_reset) begin
         state    <= cap_idle;
         waddr    <= '0;
         mon_done <= 1'b0;
      end else if (arm) begin
         // re-arm is allowed at any point, even mid-capture
         state    <= cap_armed;
         waddr    <= '0;
         mon_done <= 1'b0;
      end else begin
         case (state)
            cap_armed: begin
               if (frame_trig) begin
                  state <= cap_run;
               end
            end
            cap_run: begin
               waddr <= waddr + 1'b1;
               if (last_word) begin
                  state    <= cap_idle;
                  mon_done <= 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   // one sample per cycle while running
   always_ff @(posedge dsp_clk) begin
      if (state == cap_run) begin
         mem[waddr] <= mon_sample;
      end
   end

   assign mon_rdata = mem[rd_addr];

endmodule

// File: src/monitor_select.sv
`timescale 1ns/1ps

module monitor_select (
   input  logic                dsp_clk,
   input  logic                dsp_reset,
   input  dsp_pkg::dac_frame_t dac_out,
   input  dsp_pkg::mon_cfg_t   mon_cfg,
   input  logic                frame_trig,
   output dsp_pkg::sample_t    mon_sample
);

   logic [dsp_pkg::sample_w-1:0]     frame_cnt;
   dsp_pkg::sample_t [dsp_pkg::n_dac-1:0] chan_slice;
   dsp_pkg::sample_t                 sel;

   // cycles since the last frame trigger
   always_ff @(posedge dsp_clk) begin
      if (dsp_reset) begin
         frame_cnt <= '0;
      end else if (frame_trig) begin
         frame_cnt <= '0;
      end else begin
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

   // slice pick per channel
   always_comb begin
      for (int k = 0; k < dsp_pkg::n_dac; k++) begin
         chan_slice[k] = dac_out.smp[k*dsp_pkg::n_slice+mon_cfg.slice];
      end
   end

   always_comb begin
      case (mon_cfg.source)
         dsp_pkg::mon_dac0, dsp_pkg::mon_dac1,
         dsp_pkg::mon_dac2, dsp_pkg::mon_dac3,
         dsp_pkg::mon_dac4, dsp_pkg::mon_dac5,
         dsp_pkg::mon_dac6, dsp_pkg::mon_dac7: begin
            sel = chan_slice[mon_cfg.source[2:0]];
         end
         dsp_pkg::mon_const: sel = dsp_pkg::mon_const_val;
         dsp_pkg::mon_count: sel = frame_cnt;
         default:            sel = chan_slice[0];
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      mon_sample <= sel;
   end

endmodule

// File: src/trigger_bank.sv
`timescale 1ns/1ps

module trigger_bank (
   input  logic                 dsp_clk,
   input  logic                 dsp_reset,
   input  dsp_pkg::period_set_t period_set,
   input  logic [1:0]           period_load,
   output logic [1:0]           trig
);

   logic [dsp_pkg::period_w-1:0] cnt [dsp_pkg::n_trig];

   genvar j;
   generate
      for (j = 0; j < dsp_pkg::n_trig; j++) begin : gen_trig
         logic [dsp_pkg::period_w-1:0] last;

         // terminal count is one less than the period
         assign last    = period_set[j] - 1'b1;
         assign trig[j] = (cnt[j] == last);

         always_ff @(posedge dsp_clk) begin
            if (dsp_reset) begin
               cnt[j] <= '0;
            end else if (period_load[j] || trig[j]) begin
               // new period starts a fresh count
               cnt[j] <= '0;
            end else begin
               cnt[j] <= cnt[j] + 1'b1;
            end
         end
      end
   endgenerate

endmodule

// File: tb.f
src/dsp_pkg.sv
src/ctrl_regs.sv
src/trigger_bank.sv
src/dac_offset.sv
src/monitor_select.sv
src/monitor_capture.sv
src/dsp_core.sv
bench/tb_clock.sv
bench/dsp_core_tb.sv
